//--- src.f
+incdir+dv
source/lsuCfgPkg.sv
source/lsuOpPkg.sv
source/lsuDecode.sv
source/lsuExecute.sv
source/lsuDtim.sv
source/lsuResult.sv
source/lsu.sv
dv/lsu_asserts.sv
dv/lsuTb.sv

//--- dv/lsuTbModel.svh
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Byte-addressed reference model in hart byte order
////////////////////////////////////////////////////////////////////////////

logic [7:0]               modelMem [1 << ADR_BITS];  // One entry per byte address
logic                     modelResValid;
logic [WORD_ADR_BITS-1:0] modelResAdr;               // Reserved word index

// Little endian puts value byte i at a+i and big endian at a+n-1-i
function automatic logic [XLEN-1:0] readBytes(input logic [ADR_BITS-1:0] a, input int n,
                                              input logic be);
  logic [XLEN-1:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v[8*i +: 8] = modelMem[be ? (a + n - 1 - i) : (a + i)];
  end
  return v;
endfunction

function automatic void writeBytes(input logic [ADR_BITS-1:0] a, input int n, input logic be,
                                   input logic [XLEN-1:0] v);
  for (int i = 0; i < n; i++) begin
    modelMem[be ? (a + n - 1 - i) : (a + i)] = v[8*i +: 8];
  end
  if (modelResValid && (modelResAdr == a[ADR_BITS-1:2])) begin
    modelResValid = 1'b0;                    // Write to reserved word kills it
  end
endfunction

function automatic void reserveWord(input logic [ADR_BITS-1:0] a);
  modelResValid = 1'b1;
  modelResAdr   = a[ADR_BITS-1:2];
endfunction

// Every SC consumes the reservation
function automatic logic consumeReservation(input logic [ADR_BITS-1:0] a);
  logic ok;
  ok            = modelResValid && (modelResAdr == a[ADR_BITS-1:2]);
  modelResValid = 1'b0;
  return ok;
endfunction

function automatic logic [XLEN-1:0] extendValue(input logic [XLEN-1:0] v, input int n,
                                                input logic uns);
  case (n)
    1:       return uns ? {24'd0, v[7:0]} : {{24{v[7]}}, v[7:0]};
    2:       return uns ? {16'd0, v[15:0]} : {{16{v[15]}}, v[15:0]};
    default: return v;
  endcase
endfunction

function automatic logic [XLEN-1:0] amoApply(input logic [4:0] f, input logic [XLEN-1:0] old,
                                             input logic [XLEN-1:0] d);
  case (f)
    AMO_ADD:  return old + d;
    AMO_XOR:  return old ^ d;
    AMO_AND:  return old & d;
    AMO_OR:   return old | d;
    AMO_MIN:  return ($signed(old) <= $signed(d)) ? old : d;   // Signed
    AMO_MAX:  return ($signed(old) >= $signed(d)) ? old : d;
    AMO_MINU: return (old <= d) ? old : d;                     // Unsigned
    AMO_MAXU: return (old >= d) ? old : d;
    default:  return d;                                        // Swap
  endcase
endfunction

`endif

//--- dv/lsuTb.sv
`default_nettype none

module lsuTb;
  timeunit 1ns;
  timeprecision 100ps;
  import lsuCfgPkg::*;
  import lsuOpPkg::*;

  localparam int TIMEOUT_CYCLES = 40;    // Longest stall is 8 cycles

  logic                clk;
  logic                reset;
  logic                reqValid;
  logic [1:0]          memRw;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [1:0]          atomic;
  logic [ADR_BITS-1:0] adr;
  logic [XLEN-1:0]     writeData;
  logic                bigEndian;
  logic                stall;
  logic [XLEN-1:0]     readData;
  logic                readValid;
  logic                loadMisalignedFault;
  logic                storeMisalignedFault;
  logic                squashSc;

  integer          seed = 32'h067448e3;
  int              checkCount;
  int              errorCount;
  int              mark;                 // Error count at test start
  logic            hung;                 // Some request never got accepted
  logic [XLEN-1:0] gotData;              // Outputs sampled after acceptance
  logic            gotValid;
  logic            gotLoadFault;
  logic            gotStoreFault;
  logic            gotSquash;

`include "lsuTbModel.svh"

  lsu i_lsu (.*);

  always #10 clk = ~clk;                 // 20 ns period

  ////////////////////////////////////////////////////////////////////////////
  // Checking and request driving
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(input string what, input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (hung) return;
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Holds the request until accepted and checks that outputs stay put while stalled
  task automatic issue(input logic [1:0] rw, input logic [2:0] f3, input logic [6:0] f7,
                       input logic [1:0] at, input logic [ADR_BITS-1:0] a,
                       input logic [XLEN-1:0] d, input logic be, input int stallLen);
    int   cycles;
    logic accepted;
    cycles   = 0;
    accepted = 1'b0;
    if (hung) return;
    @(posedge clk);
    reqValid  <= 1'b1;
    memRw     <= rw;
    funct3    <= f3;
    funct7    <= f7;
    atomic    <= at;
    adr       <= a;
    writeData <= d;
    bigEndian <= be;
    stall     <= (stallLen > 0);
    while (!accepted && !hung) begin
      @(posedge clk);
      if (!stall) begin
        accepted = 1'b1;                 // DUT took it at this edge
        reqValid <= 1'b0;
      end else if (cycles + 1 >= stallLen) begin
        stall <= 1'b0;
      end
      @(negedge clk);
      if (accepted) begin
        gotData       = readData;
        gotValid      = readValid;
        gotLoadFault  = loadMisalignedFault;
        gotStoreFault = storeMisalignedFault;
        gotSquash     = squashSc;
      end else begin
        check("readData held in stall", readData, gotData);
        check("readValid held in stall", readValid, gotValid);
      end
      cycles++;
      if (!accepted && (cycles > TIMEOUT_CYCLES)) begin
        hung = 1'b1;
        $display("A request was not accepted within %0d cycles", TIMEOUT_CYCLES);
      end
    end
  endtask

  function automatic logic [2:0] sizeCode(input int n, input logic uns);
    if (n == 1) return uns ? FUNCT3_BU : FUNCT3_B;
    if (n == 2) return uns ? FUNCT3_HU : FUNCT3_H;
    return FUNCT3_W;
  endfunction

  function automatic logic [6:0] atomicF7(input logic [4:0] f);
    logic [1:0] ordering;                // aq and rl bits that the DUT ignores
    ordering = $random(seed);
    return {f, ordering};
  endfunction

  task automatic loadAndCheck(input logic [ADR_BITS-1:0] a, input int n, input logic uns,
                              input logic be, input int stallLen);
    logic [XLEN-1:0] expValue;
    expValue = extendValue(readBytes(a, n, be), n, uns);
    issue(2'b10, sizeCode(n, uns), 7'd0, 2'b00, a, $random(seed), be, stallLen);
    check($sformatf("load valid at %h", a), gotValid, 1'b1);
    check($sformatf("load data at %h size %0d", a, n), gotData, expValue);
    check($sformatf("load fault at %h", a), gotLoadFault, 1'b0);
  endtask

  task automatic storeAndCheck(input logic [ADR_BITS-1:0] a, input int n,
                               input logic [XLEN-1:0] d, input logic be, input int stallLen);
    issue(2'b01, sizeCode(n, 1'b0), 7'd0, 2'b00, a, d, be, stallLen);
    check($sformatf("store valid at %h", a), gotValid, 1'b0);
    check($sformatf("store fault at %h", a), gotStoreFault, 1'b0);
    writeBytes(a, n, be, d);
  endtask

  task automatic randomAccess(input logic be, input int stallLen);
    int                  n;
    logic [ADR_BITS-1:0] a;
    logic                uns;
    n   = 1 << ({$random(seed)} % 3);
    a   = $random(seed);
    a   = a - (a % n);                   // Aligned to the size
    uns = $random(seed);
    if ($random(seed) & 1) begin
      storeAndCheck(a, n, $random(seed), be, stallLen);
    end else begin
      loadAndCheck(a, n, uns, be, stallLen);
    end
  endtask

  task automatic misalignedAccess();
    int                  n;
    logic [ADR_BITS-1:0] a;
    logic                isStore;
    n       = ($random(seed) & 1) ? 4 : 2;
    a       = $random(seed);
    isStore = $random(seed);
    if (n == 2) a[0] = 1'b1;
    else if (a[1:0] == 2'b00) a[1:0] = 2'(1 + {$random(seed)} % 3);
    issue(isStore ? 2'b01 : 2'b10, sizeCode(n, 1'b0), 7'd0, 2'b00, a, $random(seed), 1'b0, 0);
    check($sformatf("misaligned valid at %h", a), gotValid, 1'b0);
    check($sformatf("load fault at %h", a), gotLoadFault, !isStore);
    check($sformatf("store fault at %h", a), gotStoreFault, isStore);
    loadAndCheck(a - (a % 4), 4, 1'b0, 1'b0, 0);   // Word must be unchanged
  endtask

  task automatic amoAndCheck(input logic [4:0] f, input logic [ADR_BITS-1:0] a,
                             input logic [XLEN-1:0] d, input logic be);
    logic [XLEN-1:0] old;
    old = readBytes(a, 4, be);
    issue(2'b11, FUNCT3_W, atomicF7(f), 2'b01, a, d, be, 0);
    check($sformatf("AMO %b valid", f), gotValid, 1'b1);
    check($sformatf("AMO %b old word at %h", f, a), gotData, old);
    writeBytes(a, 4, be, amoApply(f, old, d));
    loadAndCheck(a, 4, 1'b0, be, 0);
  endtask

  task automatic lrAndCheck(input logic [ADR_BITS-1:0] a);
    issue(2'b10, FUNCT3_W, atomicF7(AMO_LR), 2'b01, a, 32'd0, 1'b0, 0);
    check($sformatf("LR valid at %h", a), gotValid, 1'b1);
    check($sformatf("LR data at %h", a), gotData, readBytes(a, 4, 1'b0));
    reserveWord(a);
  endtask

  task automatic scAndCheck(input logic [ADR_BITS-1:0] a, input logic [XLEN-1:0] d);
    logic ok;
    ok = consumeReservation(a);
    issue(2'b01, FUNCT3_W, atomicF7(AMO_SC), 2'b01, a, d, 1'b0, 0);
    check($sformatf("SC valid at %h", a), gotValid, 1'b1);
    check($sformatf("SC status at %h", a), gotData, {31'd0, !ok});  // 0 means success
    check($sformatf("SC squash at %h", a), gotSquash, !ok);
    if (ok) writeBytes(a, 4, 1'b0, d);
    loadAndCheck(a, 4, 1'b0, 1'b0, 0);
  endtask

  task automatic report(input string name);
    $display("%s finished with %0d errors", name, errorCount - mark);
    mark = errorCount;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [ADR_BITS-1:0] a;
    clk           = 1'b0;
    reset         = 1'b1;
    reqValid      = 1'b0;
    stall         = 1'b0;
    bigEndian     = 1'b0;
    memRw         = '0;
    funct3        = '0;
    funct7        = '0;
    atomic        = '0;
    adr           = '0;
    writeData     = '0;
    checkCount    = 0;
    errorCount    = 0;
    mark          = 0;
    hung          = 1'b0;
    modelResValid = 1'b0;
    gotData       = '0;
    gotValid      = 1'b0;
    gotLoadFault  = 1'b0;
    gotStoreFault = 1'b0;
    gotSquash     = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check("readValid after reset", readValid, 1'b0);
    check("faults after reset", {loadMisalignedFault, storeMisalignedFault, squashSc}, 3'b000);
    report("Reset");

    for (int w = 0; w < DTIM_WORDS; w++) begin
      storeAndCheck(ADR_BITS'(w * 4), 4, $random(seed), 1'b0, 0);  // Defined contents first
    end
    repeat (300) randomAccess(1'b0, 0);
    report("Little-endian loads and stores");
    repeat (300) randomAccess(1'b1, 0);
    report("Big-endian loads and stores");
    repeat (60) misalignedAccess();
    report("Misaligned accesses");

    for (int k = 0; k < 36; k++) begin
      case (k % 9)
        0: amoAndCheck(AMO_SWAP, ADR_BITS'($random(seed) & ~3), $random(seed), $random(seed));
        1: amoAndCheck(AMO_ADD,  ADR_BITS'($random(seed) & ~3), $random(seed), $random(seed));
        2: amoAndCheck(AMO_XOR,  ADR_BITS'($random(seed) & ~3), $random(seed), $random(seed));
        3: amoAndCheck(AMO_AND,  ADR_BITS'($random(seed) & ~3), $random(seed), $random(seed));
        4: amoAndCheck(AMO_OR,   ADR_BITS'($random(seed) & ~3), $random(seed), $random(seed));
        5: amoAndCheck(AMO_MIN,  ADR_BITS'($random(seed) & ~3), $random(seed), $random(seed));
        6: amoAndCheck(AMO_MAX,  ADR_BITS'($random(seed) & ~3), $random(seed), $random(seed));
        7: amoAndCheck(AMO_MINU, ADR_BITS'($random(seed) & ~3), $random(seed), $random(seed));
        default: amoAndCheck(AMO_MAXU, ADR_BITS'($random(seed) & ~3), $random(seed),
                             $random(seed));
      endcase
    end
    report("Atomic memory operations");

    for (int k = 0; k < 4; k++) begin
      a = ADR_BITS'($random(seed) & ~3);
      lrAndCheck(a);
      scAndCheck(a, $random(seed));      // Matching reservation
      scAndCheck(a, $random(seed));      // No reservation left
      lrAndCheck(a);
      scAndCheck(a + 4, $random(seed));  // Other word
      lrAndCheck(a);
      storeAndCheck(a, 4, $random(seed), 1'b0, 0);
      scAndCheck(a, $random(seed));      // Lost to a store
      lrAndCheck(a);
      scAndCheck(a, $random(seed));
      scAndCheck(a, $random(seed));      // Second SC fails
    end
    report("LR and SC");

    repeat (40) randomAccess($random(seed), 1 + {$random(seed)} % 8);
    report("Stall");

    errorCount += i_lsu.i_lsuExecute.i_lsuExecuteAsserts.failCount;
    $display("Done with %0d checks and %0d errors", checkCount, errorCount);
    if (!hung && (errorCount == 0)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/lsu_asserts.sv
`default_nettype none

module lsuExecuteAsserts (
  input logic                                clk,
  input logic                                reset,
  input logic                                accept,
  input lsuOpPkg::memOpKind                  opKind,
  input logic [1:0]                          size,
  input logic [1:0]                          adrLow,
  input logic                                misaligned,
  input logic [lsuCfgPkg::WORD_ADR_BITS-1:0] dtimAdr,
  input logic                                dtimWrite,
  input logic                                scFail
);
  timeunit 1ns;
  timeprecision 100ps;
  import lsuCfgPkg::*;
  import lsuOpPkg::*;

  int                       failCount = 0;  // Read by the testbench at the end
  logic                     aligned;        // Offset is a multiple of the access size
  logic                     shadowValid;    // Reservation as LR, SC and writes leave it
  logic [WORD_ADR_BITS-1:0] shadowAdr;

  assign aligned = (size == 2'b00) || ((size == 2'b01) && !adrLow[0]) || (adrLow == 2'b00);

  ////////////////////////////////////////////////////////////////////////////
  // Shadow of the single reservation
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      shadowValid <= 1'b0;
    end else if (accept) begin
      if (opKind == opSc) begin
        shadowValid <= 1'b0;             // Taken by any SC
      end else if ((opKind == opLr) && !misaligned) begin
        shadowValid <= 1'b1;
        shadowAdr   <= dtimAdr;
      end else if (((opKind == opStore) || (opKind == opAmo)) && !misaligned &&
                   (dtimAdr == shadowAdr)) begin
        shadowValid <= 1'b0;             // Reserved word overwritten
      end
    end
  end

  noMisalignedWrite: assert property (@(posedge clk) disable iff (reset)
    dtimWrite |-> aligned)
    else begin
      failCount++;
      $error("DTIM written by a misaligned request");
    end

  noWriteWithoutAccept: assert property (@(posedge clk) disable iff (reset)
    dtimWrite |-> accept)
    else begin
      failCount++;
      $error("DTIM written without an accepted request");
    end

  // Matching reservation means the SC must succeed
  scSucceeds: assert property (@(posedge clk) disable iff (reset)
    (accept && (opKind == opSc) && shadowValid && (shadowAdr == dtimAdr) && !misaligned)
      |-> !scFail)
    else begin
      failCount++;
      $error("SC failed although the reservation matched");
    end

endmodule

bind lsuExecute lsuExecuteAsserts i_lsuExecuteAsserts (
  .clk(clk), .reset(reset), .accept(accept), .opKind(opKind), .size(size),
  .adrLow(adr[1:0]), .misaligned(misaligned), .dtimAdr(dtimAdr), .dtimWrite(dtimWrite),
  .scFail(scFail)
);

`default_nettype wire

//--- source/lsu.sv
`default_nettype none

module lsu (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           reqValid,
  input  logic [1:0]                     memRw,      // 10 read, 01 write, 11 AMO
  input  logic [2:0]                     funct3,
  input  logic [6:0]                     funct7,
  input  logic [1:0]                     atomic,
  input  logic [lsuCfgPkg::ADR_BITS-1:0] adr,
  input  logic [lsuCfgPkg::XLEN-1:0]     writeData,
  input  logic                           bigEndian,
  input  logic                           stall,
  output logic [lsuCfgPkg::XLEN-1:0]     readData,
  output logic                           readValid,
  output logic                           loadMisalignedFault,
  output logic                           storeMisalignedFault,
  output logic                           squashSc
);
  import lsuCfgPkg::*;
  import lsuOpPkg::*;

  // Decoded request
  logic                      accept;
  memOpKind                  opKind;
  logic [1:0]                size;
  logic                      isUnsigned;
  logic [4:0]                amoFunct;
  logic                      misaligned;

  // DTIM port
  logic [WORD_ADR_BITS-1:0]  dtimAdr;
  logic                      dtimWrite;
  logic [BYTES_PER_WORD-1:0] dtimByteMask;
  logic [XLEN-1:0]           dtimWriteData;
  logic [XLEN-1:0]           dtimReadWord;

  logic [XLEN-1:0]           loadValue;    // AMO operand
  logic                      scFail;

  lsuDecode i_lsuDecode (
    .reqValid, .stall, .memRw, .funct3, .funct7, .atomic, .adrLow(adr[1:0]),
    .accept, .opKind, .size, .isUnsigned, .amoFunct, .misaligned
  );

  lsuExecute i_lsuExecute (
    .clk, .reset, .accept, .opKind, .size, .amoFunct, .misaligned, .adr, .writeData,
    .bigEndian, .loadValue, .dtimAdr, .dtimWrite, .dtimByteMask, .dtimWriteData, .scFail
  );

  lsuDtim i_lsuDtim (
    .clk, .dtimAdr, .dtimWrite, .dtimByteMask, .dtimWriteData, .dtimReadWord
  );

  lsuResult i_lsuResult (
    .clk, .reset, .accept, .opKind, .size, .isUnsigned, .misaligned, .adrLow(adr[1:0]),
    .bigEndian, .dtimReadWord, .scFail, .loadValue, .readData, .readValid,
    .loadMisalignedFault, .storeMisalignedFault, .squashSc
  );

endmodule

`default_nettype wire

//--- source/lsuResult.sv
`default_nettype none

module lsuResult (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       accept,
  input  lsuOpPkg::memOpKind         opKind,
  input  logic [1:0]                 size,
  input  logic                       isUnsigned,
  input  logic                       misaligned,
  input  logic [1:0]                 adrLow,
  input  logic                       bigEndian,
  input  logic [lsuCfgPkg::XLEN-1:0] dtimReadWord,
  input  logic                       scFail,
  output logic [lsuCfgPkg::XLEN-1:0] loadValue,     // Sign-extended, current request
  output logic [lsuCfgPkg::XLEN-1:0] readData,
  output logic                       readValid,
  output logic                       loadMisalignedFault,
  output logic                       storeMisalignedFault,
  output logic                       squashSc
);
  import lsuCfgPkg::*;
  import lsuOpPkg::*;

  memWord          raw;
  memWord          little;     // Word in hart byte order
  logic [1:0]      laneAdr;    // Offset corrected for big endian
  logic [7:0]      laneByte;
  logic [15:0]     laneHalf;
  logic [XLEN-1:0] zeroValue;
  logic            isLoad;     // Load or LR
  logic            isStore;    // Store, SC or AMO

  assign raw.word     = dtimReadWord;
  assign little.bytes = bigEndian ? {raw.bytes[0], raw.bytes[1], raw.bytes[2], raw.bytes[3]}
                                  : raw.bytes;

  // Swapping the word moves each lane to the mirrored position
  assign laneAdr  = adrLow ^ {2{bigEndian}};
  assign laneByte = little.bytes[laneAdr];
  assign laneHalf = little.halves[laneAdr[1]];

  always_comb begin
    case (size)
      2'b00: begin
        loadValue = {{(XLEN-8){laneByte[7]}}, laneByte};
        zeroValue = {{(XLEN-8){1'b0}}, laneByte};
      end
      2'b01: begin
        loadValue = {{(XLEN-16){laneHalf[15]}}, laneHalf};
        zeroValue = {{(XLEN-16){1'b0}}, laneHalf};
      end
      default: begin
        loadValue = little.word;
        zeroValue = little.word;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result register, M to W
  ////////////////////////////////////////////////////////////////////////////

  assign isLoad  = (opKind == opLoad) | (opKind == opLr);
  assign isStore = (opKind == opStore) | (opKind == opSc) | (opKind == opAmo);

  always_ff @(posedge clk) begin
    if (reset) begin
      readValid            <= 1'b0;
      loadMisalignedFault  <= 1'b0;
      storeMisalignedFault <= 1'b0;
      squashSc             <= 1'b0;
    end else if (accept) begin                 // Held through stall
      readValid            <= (isLoad | (opKind == opSc) | (opKind == opAmo)) & ~misaligned;
      loadMisalignedFault  <= isLoad & misaligned;
      storeMisalignedFault <= isStore & misaligned;
      squashSc             <= (opKind == opSc) & scFail & ~misaligned;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      if (opKind == opSc) begin
        readData <= {{(XLEN-1){1'b0}}, scFail};  // 0 on success
      end else begin
        readData <= isUnsigned ? zeroValue : loadValue;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/lsuDtim.sv
`default_nettype none

module lsuDtim (
  input  logic                                 clk,
  input  logic [lsuCfgPkg::WORD_ADR_BITS-1:0]  dtimAdr,
  input  logic                                 dtimWrite,
  input  logic [lsuCfgPkg::BYTES_PER_WORD-1:0] dtimByteMask,
  input  logic [lsuCfgPkg::XLEN-1:0]           dtimWriteData,
  output logic [lsuCfgPkg::XLEN-1:0]           dtimReadWord
);
  import lsuCfgPkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Scratchpad array
  ////////////////////////////////////////////////////////////////////////////

  logic [XLEN-1:0] mem [DTIM_WORDS];  // Contents undefined until written

  // Read is combinational, so an AMO sees the old word in its own cycle
  assign dtimReadWord = mem[dtimAdr];

  // Byte lanes update independently
  always_ff @(posedge clk) begin
    if (dtimWrite) begin
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
        if (dtimByteMask[i]) begin
          mem[dtimAdr][8*i +: 8] <= dtimWriteData[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/lsuExecute.sv
`default_nettype none

module lsuExecute (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 accept,
  input  lsuOpPkg::memOpKind                   opKind,
  input  logic [1:0]                           size,
  input  logic [4:0]                           amoFunct,
  input  logic                                 misaligned,
  input  logic [lsuCfgPkg::ADR_BITS-1:0]       adr,
  input  logic [lsuCfgPkg::XLEN-1:0]           writeData,
  input  logic                                 bigEndian,
  input  logic [lsuCfgPkg::XLEN-1:0]           loadValue,     // Old word for AMOs
  output logic [lsuCfgPkg::WORD_ADR_BITS-1:0]  dtimAdr,
  output logic                                 dtimWrite,
  output logic [lsuCfgPkg::BYTES_PER_WORD-1:0] dtimByteMask,
  output logic [lsuCfgPkg::XLEN-1:0]           dtimWriteData,
  output logic                                 scFail
);
  import lsuCfgPkg::*;
  import lsuOpPkg::*;

  logic [WORD_ADR_BITS-1:0] resAdr;      // Reserved word index
  logic                     resValid;
  logic                     resHit;      // Request targets the reserved word
  logic                     isSc;
  logic                     scOk;
  logic                     writesWord;  // Aligned store or AMO
  logic [1:0]               offset;      // Byte within the word
  logic [XLEN-1:0]          amoResult;
  logic [XLEN-1:0]          storeSrc;
  memWord                   placed;      // Data replicated over the lanes
  memWord                   swapped;

  assign dtimAdr = adr[ADR_BITS-1:ADR_BITS-WORD_ADR_BITS];
  assign offset  = adr[1:0];

  ////////////////////////////////////////////////////////////////////////////
  // LR/SC reservation, a single word
  ////////////////////////////////////////////////////////////////////////////

  assign isSc       = (opKind == opSc);
  assign resHit     = resValid & (resAdr == dtimAdr);
  assign scOk       = isSc & resHit & ~misaligned;
  assign scFail     = isSc & ~scOk;
  assign writesWord = ((opKind == opStore) | (opKind == opAmo)) & ~misaligned;

  always_ff @(posedge clk) begin
    if (reset) begin
      resValid <= 1'b0;
    end else if (accept) begin
      if (isSc || (writesWord && resHit)) begin
        resValid <= 1'b0;                // Any SC consumes it
      end else if ((opKind == opLr) && !misaligned) begin
        resValid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && (opKind == opLr) && !misaligned) begin
      resAdr <= dtimAdr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // AMO arithmetic on the old word
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (amoFunct)
      AMO_SWAP: amoResult = writeData;
      AMO_ADD:  amoResult = loadValue + writeData;
      AMO_XOR:  amoResult = loadValue ^ writeData;
      AMO_AND:  amoResult = loadValue & writeData;
      AMO_OR:   amoResult = loadValue | writeData;
      AMO_MIN:  amoResult = ($signed(loadValue) < $signed(writeData)) ? loadValue : writeData;
      AMO_MAX:  amoResult = ($signed(loadValue) > $signed(writeData)) ? loadValue : writeData;
      AMO_MINU: amoResult = (loadValue < writeData) ? loadValue : writeData;
      AMO_MAXU: amoResult = (loadValue > writeData) ? loadValue : writeData;
      default:  amoResult = writeData;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Store data and byte mask
  ////////////////////////////////////////////////////////////////////////////

  assign storeSrc = (opKind == opAmo) ? amoResult : writeData;

  // Same data in every lane, the mask picks the one written
  always_comb begin
    case (size)
      2'b00:   placed.bytes  = {BYTES_PER_WORD{storeSrc[7:0]}};
      2'b01:   placed.halves = {2{storeSrc[15:0]}};
      default: placed.word   = storeSrc;
    endcase
  end

  // Big-endian memory holds the bytes reversed
  assign swapped.bytes = {placed.bytes[0], placed.bytes[1],
                          placed.bytes[2], placed.bytes[3]};
  assign dtimWriteData = bigEndian ? swapped.word : placed.word;

  always_comb begin
    case (size)
      2'b00:   dtimByteMask = 4'b0001 << offset;
      2'b01:   dtimByteMask = 4'b0011 << {offset[1], 1'b0};
      default: dtimByteMask = '1;
    endcase
  end

  assign dtimWrite = accept & (writesWord | scOk);  // Failed SC writes nothing

endmodule

`default_nettype wire

//--- source/lsuDecode.sv
`default_nettype none

module lsuDecode (
  input  logic               reqValid,
  input  logic               stall,
  input  logic [1:0]         memRw,       // 10 read, 01 write, 11 AMO
  input  logic [2:0]         funct3,
  input  logic [6:0]         funct7,
  input  logic [1:0]         atomic,      // Nonzero for LR, SC and AMOs
  input  logic [1:0]         adrLow,
  output logic               accept,
  output lsuOpPkg::memOpKind opKind,
  output logic [1:0]         size,        // log2 of the access bytes
  output logic               isUnsigned,
  output logic [4:0]         amoFunct,
  output logic               misaligned
);
  import lsuOpPkg::*;

  logic isAtomic;

  assign accept   = reqValid & ~stall;   // Taken at this rising edge
  assign amoFunct = funct7[6:2];
  assign isAtomic = |atomic;

  // Operation kind
  always_comb begin
    if (isAtomic && (memRw != 2'b00)) begin
      case (amoFunct)
        AMO_LR:  opKind = opLr;
        AMO_SC:  opKind = opSc;
        default: opKind = opAmo;         // All other funct5 are arithmetic
      endcase
    end else begin
      case (memRw)
        2'b10:   opKind = opLoad;
        2'b01:   opKind = opStore;
        default: opKind = opNone;        // 11 needs the atomic field
      endcase
    end
  end

  // Access size and extension
  always_comb begin
    size       = 2'b10;
    isUnsigned = 1'b0;
    case (funct3)
      FUNCT3_B:  size = 2'b00;
      FUNCT3_H:  size = 2'b01;
      FUNCT3_W:  size = 2'b10;
      FUNCT3_BU: begin
        size       = 2'b00;
        isUnsigned = 1'b1;
      end
      FUNCT3_HU: begin
        size       = 2'b01;
        isUnsigned = 1'b1;
      end
      default:   size = 2'b10;           // No doubleword on RV32
    endcase
    if (isAtomic) begin
      size       = 2'b10;                // A extension is word only here
      isUnsigned = 1'b0;
    end
  end

  // Offset must be a multiple of the size
  always_comb begin
    case (size)
      2'b00:   misaligned = 1'b0;
      2'b01:   misaligned = adrLow[0];
      default: misaligned = |adrLow;
    endcase
    if (opKind == opNone) begin
      misaligned = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/lsuOpPkg.sv
`default_nettype none

// Encodings seen by the LSU and the views of one memory word
package lsuOpPkg;

  ////////////////////////////////////////////////////////////////////////////
  // funct3 size codes of loads and stores
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [2:0] FUNCT3_B  = 3'b000;  // lb / sb
  localparam logic [2:0] FUNCT3_H  = 3'b001;  // lh / sh
  localparam logic [2:0] FUNCT3_W  = 3'b010;  // lw / sw, also all atomics
  localparam logic [2:0] FUNCT3_BU = 3'b100;  // lbu
  localparam logic [2:0] FUNCT3_HU = 3'b101;  // lhu

  ////////////////////////////////////////////////////////////////////////////
  // funct5 codes of the A extension, taken from funct7[6:2]
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [4:0] AMO_ADD  = 5'b00000;
  localparam logic [4:0] AMO_SWAP = 5'b00001;
  localparam logic [4:0] AMO_LR   = 5'b00010;
  localparam logic [4:0] AMO_SC   = 5'b00011;
  localparam logic [4:0] AMO_XOR  = 5'b00100;
  localparam logic [4:0] AMO_OR   = 5'b01000;
  localparam logic [4:0] AMO_AND  = 5'b01100;
  localparam logic [4:0] AMO_MIN  = 5'b10000;  // Signed compare
  localparam logic [4:0] AMO_MAX  = 5'b10100;
  localparam logic [4:0] AMO_MINU = 5'b11000;  // Unsigned compare
  localparam logic [4:0] AMO_MAXU = 5'b11100;

  // Decoded kind of a request
  typedef enum logic [2:0] {
    opNone  = 3'd0,  // Idle or unsupported encoding
    opLoad  = 3'd1,
    opStore = 3'd2,
    opLr    = 3'd3,  // Load reserved
    opSc    = 3'd4,  // Store conditional
    opAmo   = 3'd5   // Read-modify-write
  } memOpKind;

  // One DTIM word, as a whole, by halfword or by byte lane
  typedef union packed {
    logic [lsuCfgPkg::XLEN-1:0] word;
    logic [1:0][15:0]           halves;
    logic [3:0][7:0]            bytes;
  } memWord;

endpackage

`default_nettype wire

//--- source/lsuCfgPkg.sv
`default_nettype none

// Sizes of the hart datapath and of the data scratchpad
package lsuCfgPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Hart
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN           = 32;        // Integer register width
  localparam int BYTES_PER_WORD = XLEN / 8;  // Byte lanes in one data word

  ////////////////////////////////////////////////////////////////////////////
  // DTIM
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADR_BITS      = 10;                  // Byte address, 1 KiB
  localparam int DTIM_WORDS    = 256;                 // Depth in words
  localparam int WORD_ADR_BITS = $clog2(DTIM_WORDS);  // Byte offset dropped

endpackage

`default_nettype wire
